// ==== hdl/ts_monitor_pkg.sv ====
`default_nettype none

package ts_monitor_pkg;

	// Transport stream packet geometry.
	localparam int ts_packet_bytes = 188;
	localparam logic [7:0] ts_sync_byte = 8'h47;

	// 188 bytes split evenly into 32-bit words.
	localparam int ts_word_bytes = 4;
	localparam int ts_word_count = ts_packet_bytes / ts_word_bytes;
	localparam int ts_data_width = 8 * ts_word_bytes;

	localparam int ts_pid_width = 13;

	typedef logic [ts_data_width-1:0] ts_word_t;
	typedef logic [ts_pid_width-1:0] ts_pid_t;
	typedef logic [7:0] ts_byte_idx_t; // Position 0 to 187.
	typedef logic [5:0] ts_word_idx_t; // Word 0 to 46.

	// Header fields in wire order, byte 0 in the top bits.
	typedef struct packed {
		logic [7:0] sync;
		logic transport_error;
		logic payload_start;
		logic priority_flag;
		ts_pid_t pid;
		logic [1:0] scrambling;
		logic [1:0] adaptation_ctrl;
		logic [3:0] continuity;
	} ts_header_fields_t;

	// The first four packet bytes, seen raw or decoded.
	typedef union packed {
		logic [3:0][7:0] bytes; // bytes[3] is packet byte 0.
		ts_header_fields_t fields;
	} ts_header_u;

endpackage

`default_nettype wire

// ==== hdl/ts_header_parser.sv ====
`default_nettype none

module ts_header_parser import ts_monitor_pkg::*; (
	input wire mpeg_clk,
	input wire S_AXI_ARESETN,

	input wire [7:0] mpeg_data,
	input wire mpeg_valid,
	input wire mpeg_sync,
	input wire ts_pid_t pid,

	output logic byte_wr,
	output ts_byte_idx_t byte_idx,
	output logic [7:0] byte_data,
	output logic capture_drop,
	output logic matched_state
);

	localparam ts_byte_idx_t last_idx = ts_byte_idx_t'(ts_packet_bytes - 1);
	localparam ts_byte_idx_t pid_lo_idx = 8'd2;

	logic tracking;
	ts_byte_idx_t pos;
	logic [1:0][7:0] hdr_q; // Packet bytes 0 and 1.
	ts_header_u hdr_chk;

	logic take_first;
	logic take_next;
	logic decide;
	logic hdr_ok;

	assign take_first = mpeg_valid && mpeg_sync;
	assign take_next = mpeg_valid && !mpeg_sync && tracking;
	assign decide = take_next && (pos == pid_lo_idx);

	// Header as it stands once the PID low byte is on the bus.
	always_comb begin
		hdr_chk.bytes[3:2] = hdr_q;
		hdr_chk.bytes[1] = mpeg_data;
		hdr_chk.bytes[0] = 8'h00;
	end

	assign hdr_ok = (hdr_chk.fields.sync == ts_sync_byte) &&
		(hdr_chk.fields.pid == pid);

	// Byte position within the packet.
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			tracking <= 1'b0;
			pos <= '0;
		end else if (take_first) begin
			tracking <= 1'b1;
			pos <= 8'd1;
		end else if (take_next) begin
			pos <= pos + 8'd1;
			if (pos == last_idx) begin
				tracking <= 1'b0; // Idle until next sync.
			end
		end
	end

	// Collect header bytes 0 and 1.
	always_ff @(posedge mpeg_clk) begin
		if (take_first) begin
			hdr_q[1] <= mpeg_data;
		end else if (take_next && (pos == 8'd1)) begin
			hdr_q[0] <= mpeg_data;
		end
	end

	// Forward tracked bytes one cycle later.
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			byte_wr <= 1'b0;
			capture_drop <= 1'b0;
			matched_state <= 1'b0;
		end else begin
			byte_wr <= take_first || take_next;
			capture_drop <= decide && !hdr_ok;
			if (decide) begin
				matched_state <= hdr_ok;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (take_first) begin
			byte_idx <= '0;
			byte_data <= mpeg_data;
		end else if (take_next) begin
			byte_idx <= pos;
			byte_data <= mpeg_data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ts_packet_buffer.sv ====
`default_nettype none

module ts_packet_buffer import ts_monitor_pkg::*; (
	input wire mpeg_clk,
	input wire S_AXI_ARESETN,

	// Byte stream from the parser.
	input wire byte_wr,
	input wire ts_byte_idx_t byte_idx,
	input wire [7:0] byte_data,
	input wire capture_drop,

	// Read side.
	input wire packet_release,
	input wire ts_word_idx_t rd_addr,
	output ts_word_t rd_data,
	output logic packet_ready
);

	localparam ts_byte_idx_t last_idx = ts_byte_idx_t'(ts_packet_bytes - 1);

	ts_word_t bank_mem [0:1][0:ts_word_count-1];

	logic wr_bank; // Read bank is the other one.
	logic rd_bank;
	logic drop_q;

	ts_word_idx_t wr_word;
	logic [1:0] wr_lane;
	logic first_byte;
	logic last_byte;
	logic complete;

	assign wr_word = ts_word_idx_t'(byte_idx / ts_word_bytes);
	assign wr_lane = 2'(byte_idx % ts_word_bytes);

	assign first_byte = byte_wr && (byte_idx == '0);
	assign last_byte = byte_wr && (byte_idx == last_idx);
	assign complete = last_byte && !drop_q;

	assign rd_bank = ~wr_bank;

	// Lane write into the bank being filled.
	always_ff @(posedge mpeg_clk) begin
		if (byte_wr) begin
			bank_mem[wr_bank][wr_word][8*wr_lane +: 8] <= byte_data;
		end
	end

	// Drop flag for the packet in progress.
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			drop_q <= 1'b0;
		end else if (first_byte) begin
			drop_q <= 1'b0;
		end else if (capture_drop) begin
			drop_q <= 1'b1;
		end
	end

	// Bank swap on completion, unless the read bank is still held.
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			wr_bank <= 1'b0;
			packet_ready <= 1'b0;
		end else begin
			if (complete && !packet_ready) begin
				wr_bank <= ~wr_bank;
				packet_ready <= 1'b1;
			end else if (packet_release) begin
				packet_ready <= 1'b0;
			end
		end
	end

	assign rd_data = bank_mem[rd_bank][rd_addr];

endmodule

`default_nettype wire

// ==== hdl/ts_packet_pump.sv ====
`default_nettype none

module ts_packet_pump import ts_monitor_pkg::*; (
	input wire mpeg_clk,
	input wire S_AXI_ARESETN,

	input wire pump_data_enable,
	input wire packet_ready,

	output ts_word_idx_t rd_addr,
	input wire ts_word_t rd_data,

	output ts_word_t out_data,
	output ts_word_idx_t out_data_index,
	output logic out_valid,
	output logic ready_for_read,
	output logic packet_release
);

	localparam ts_word_idx_t last_word_idx = ts_word_idx_t'(ts_word_count - 1);

	ts_word_idx_t rd_idx;
	logic draining; // Bank done, waiting for release to land.
	logic issue;
	logic last_word;

	assign issue = pump_data_enable && packet_ready && !draining;
	assign rd_addr = rd_idx;

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			rd_idx <= '0;
			draining <= 1'b0;
		end else begin
			if (issue) begin
				if (rd_idx == last_word_idx) begin
					rd_idx <= '0;
					draining <= 1'b1;
				end else begin
					rd_idx <= rd_idx + 6'd1;
				end
			end else begin
				rd_idx <= '0; // Restart from word 0.
			end
			if (!packet_ready) begin
				draining <= 1'b0;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			out_valid <= 1'b0;
			last_word <= 1'b0;
			ready_for_read <= 1'b0;
			packet_release <= 1'b0;
		end else begin
			out_valid <= issue;
			last_word <= issue && (rd_idx == last_word_idx);
			ready_for_read <= last_word;
			packet_release <= last_word;
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (issue) begin
			out_data <= rd_data;
			out_data_index <= rd_idx;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ts_monitor.sv ====
`default_nettype none

module ts_monitor import ts_monitor_pkg::*; (
	input wire mpeg_clk,
	input wire S_AXI_ARESETN,

	input wire [7:0] mpeg_data,
	input wire mpeg_valid,
	input wire mpeg_sync,
	input wire ts_pid_t pid,

	input wire pump_data_enable,

	output ts_word_t out_data,
	output ts_word_idx_t out_data_index,
	output logic out_valid,
	output logic ready_for_read,
	output logic matched_state,
	output logic packet_ready
);

	logic byte_wr;
	ts_byte_idx_t byte_idx;
	logic [7:0] byte_data;
	logic capture_drop;

	ts_word_idx_t rd_addr;
	ts_word_t rd_data;
	logic packet_release;

	ts_header_parser ts_header_parser_i (
		.mpeg_clk (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.mpeg_data (mpeg_data),
		.mpeg_valid (mpeg_valid),
		.mpeg_sync (mpeg_sync),
		.pid (pid),
		.byte_wr (byte_wr),
		.byte_idx (byte_idx),
		.byte_data (byte_data),
		.capture_drop (capture_drop),
		.matched_state (matched_state)
	);

	ts_packet_buffer ts_packet_buffer_i (
		.mpeg_clk (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.byte_wr (byte_wr),
		.byte_idx (byte_idx),
		.byte_data (byte_data),
		.capture_drop (capture_drop),
		.packet_release (packet_release),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.packet_ready (packet_ready)
	);

	ts_packet_pump ts_packet_pump_i (
		.mpeg_clk (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.pump_data_enable (pump_data_enable),
		.packet_ready (packet_ready),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.out_data (out_data),
		.out_data_index (out_data_index),
		.out_valid (out_valid),
		.ready_for_read (ready_for_read),
		.packet_release (packet_release)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
	output logic mpeg_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period = 5; // 10 ns period.

	initial begin
		mpeg_clk = 1'b0;
	end

	always #half_period mpeg_clk = ~mpeg_clk;

endmodule

`default_nettype wire

// ==== tb/ts_monitor_chk.sv ====
`default_nettype none

module ts_monitor_chk import ts_monitor_pkg::*; (
	input wire mpeg_clk,
	input wire S_AXI_ARESETN,
	input wire pump_data_enable,
	input wire out_valid,
	input wire ready_for_read,
	input wire ts_word_idx_t out_data_index
);
	timeunit 1ns;
	timeprecision 100ps;

	// A word is only issued while readout is requested.
	valid_needs_enable: assert property (
		@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		out_valid |-> $past(pump_data_enable)
	) else $error("out_valid without pump_data_enable one cycle earlier");

	ready_single_pulse: assert property (
		@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		ready_for_read |=> !ready_for_read
	) else $error("ready_for_read held longer than one cycle");

	index_in_range: assert property (
		@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		out_valid |-> (out_data_index < ts_word_idx_t'(ts_word_count))
	) else $error("out_data_index beyond the last word of a packet");

endmodule

`default_nettype wire

// ==== tb/ts_monitor_tb.sv ====
`default_nettype none

module ts_monitor_tb import ts_monitor_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 10;
	localparam int packets_sent = 9; // Over all six tests.
	localparam int cycles_per_packet = 400;
	localparam int timeout_cycles = reset_cycles + packets_sent * cycles_per_packet;
	localparam ts_pid_t watched_pid = 13'h0abc;
	localparam ts_pid_t other_pid = 13'h0abd;

	logic mpeg_clk;
	logic S_AXI_ARESETN;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	ts_pid_t pid;
	logic pump_data_enable;
	ts_word_t out_data;
	ts_word_idx_t out_data_index;
	logic out_valid;
	logic ready_for_read;
	logic matched_state;
	logic packet_ready;

	logic [7:0] sent_bytes [0:ts_packet_bytes-1];
	logic [7:0] held_bytes [0:ts_packet_bytes-1]; // What the DUT should hold.
	logic [3:0] continuity;
	int cycle_count = 0;

	tb_clock_gen tb_clock_gen_i (.mpeg_clk (mpeg_clk));

	ts_monitor ts_monitor_i (
		.mpeg_clk (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.mpeg_data (mpeg_data),
		.mpeg_valid (mpeg_valid),
		.mpeg_sync (mpeg_sync),
		.pid (pid),
		.pump_data_enable (pump_data_enable),
		.out_data (out_data),
		.out_data_index (out_data_index),
		.out_valid (out_valid),
		.ready_for_read (ready_for_read),
		.matched_state (matched_state),
		.packet_ready (packet_ready)
	);

	bind ts_monitor ts_monitor_chk ts_monitor_chk_i (
		.mpeg_clk (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.pump_data_enable (pump_data_enable),
		.out_valid (out_valid),
		.ready_for_read (ready_for_read),
		.out_data_index (out_data_index)
	);

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic compare_word(input string name, input ts_word_t expected,
		input ts_word_t actual);
		if (actual !== expected) begin
			$display("error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic compare_index(input string name, input ts_word_idx_t expected,
		input ts_word_idx_t actual);
		if (actual !== expected) begin
			$display("error: time %0t, %s expected %0d, got %0d", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error: time %0t, %s expected %b, got %b", $time, name, expected, actual);
			stop_run();
		end
	endtask

	always @(posedge mpeg_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == timeout_cycles) begin
			$display("timeout: run still going after %0d cycles", timeout_cycles);
			stop_run();
		end
	end

	// Word n holds bytes 4n to 4n+3, lowest byte in the low lane.
	function automatic ts_word_t expected_word(input int n);
		return {held_bytes[4*n+3], held_bytes[4*n+2], held_bytes[4*n+1], held_bytes[4*n]};
	endfunction

	task automatic send_packet(input ts_pid_t pkt_pid, input logic [7:0] sync_value,
		input int max_gap);
		ts_header_u hdr;
		int gap;
		int i;
		hdr.fields.sync = sync_value;
		hdr.fields.transport_error = 1'b0;
		hdr.fields.payload_start = 1'b1;
		hdr.fields.priority_flag = 1'b0;
		hdr.fields.pid = pkt_pid;
		hdr.fields.scrambling = 2'b00;
		hdr.fields.adaptation_ctrl = 2'b01; // Payload only.
		hdr.fields.continuity = continuity;
		continuity = continuity + 4'd1;
		for (i = 0; i < ts_packet_bytes; i++) begin
			sent_bytes[i] = (i < 4) ? hdr.bytes[3 - i] : 8'($urandom);
		end
		for (i = 0; i < ts_packet_bytes; i++) begin
			gap = (i > 0 && max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
			repeat (gap) begin
				@(posedge mpeg_clk);
				mpeg_data <= 8'($urandom); // Junk while idle.
				mpeg_valid <= 1'b0;
				mpeg_sync <= 1'b0;
			end
			@(posedge mpeg_clk);
			mpeg_data <= sent_bytes[i];
			mpeg_valid <= 1'b1;
			mpeg_sync <= (i == 0);
		end
		@(posedge mpeg_clk);
		mpeg_valid <= 1'b0;
		mpeg_sync <= 1'b0;
	endtask

	// packet_ready one and two cycles after the last byte.
	task automatic check_ready_edge(input logic first, input logic second);
		@(negedge mpeg_clk);
		compare_bit("packet_ready", first, packet_ready);
		@(negedge mpeg_clk);
		compare_bit("packet_ready", second, packet_ready);
	endtask

	task automatic check_word_out(input int n);
		compare_bit("out_valid", 1'b1, out_valid);
		compare_index("out_data_index", ts_word_idx_t'(n), out_data_index);
		compare_word("out_data", expected_word(n), out_data);
	endtask

	// Reads words 0 to stop_at-1, then drops the enable unless the packet is done.
	task automatic read_packet(input int stop_at);
		int n;
		int waited;
		@(posedge mpeg_clk);
		pump_data_enable <= 1'b1;
		waited = 0;
		@(negedge mpeg_clk);
		while (!out_valid && waited < 4) begin
			waited++;
			@(negedge mpeg_clk);
		end
		if (!out_valid) begin
			$display("out_valid never rose after pump_data_enable went high");
			stop_run();
		end
		for (n = 0; n < stop_at; n++) begin
			if (n > 0) begin
				@(negedge mpeg_clk);
			end
			check_word_out(n);
		end
		if (stop_at < ts_word_count) begin
			@(posedge mpeg_clk);
			pump_data_enable <= 1'b0;
			@(negedge mpeg_clk);
			check_word_out(stop_at); // Issued on the edge that saw the enable drop.
			@(negedge mpeg_clk);
			compare_bit("out_valid", 1'b0, out_valid);
			compare_bit("ready_for_read", 1'b0, ready_for_read);
			compare_bit("packet_ready", 1'b1, packet_ready);
		end else begin
			@(negedge mpeg_clk);
			compare_bit("ready_for_read", 1'b1, ready_for_read);
			compare_bit("out_valid", 1'b0, out_valid);
			@(posedge mpeg_clk);
			pump_data_enable <= 1'b0;
			@(negedge mpeg_clk);
			compare_bit("ready_for_read", 1'b0, ready_for_read);
			compare_bit("packet_ready", 1'b0, packet_ready);
		end
	endtask

	task automatic capture_and_read(input int max_gap);
		send_packet(watched_pid, ts_sync_byte, max_gap);
		held_bytes = sent_bytes;
		check_ready_edge(1'b0, 1'b1);
		compare_bit("matched_state", 1'b1, matched_state);
		read_packet(ts_word_count);
	endtask

	task automatic test_matching_capture();
		capture_and_read(0);
	endtask

	task automatic test_pid_mismatch();
		send_packet(other_pid, ts_sync_byte, 0);
		check_ready_edge(1'b0, 1'b0);
		compare_bit("matched_state", 1'b0, matched_state);
		capture_and_read(0);
	endtask

	task automatic test_bad_sync();
		send_packet(watched_pid, 8'h46, 0);
		check_ready_edge(1'b0, 1'b0);
		compare_bit("matched_state", 1'b0, matched_state);
	endtask

	task automatic test_valid_gaps();
		capture_and_read(2);
	endtask

	task automatic test_second_dropped();
		send_packet(watched_pid, ts_sync_byte, 0);
		held_bytes = sent_bytes;
		check_ready_edge(1'b0, 1'b1);
		send_packet(watched_pid, ts_sync_byte, 0);
		check_ready_edge(1'b1, 1'b1);
		read_packet(ts_word_count); // First packet still held.
		capture_and_read(0);
	endtask

	task automatic test_pause_resume();
		send_packet(watched_pid, ts_sync_byte, 0);
		held_bytes = sent_bytes;
		check_ready_edge(1'b0, 1'b1);
		read_packet(12);
		read_packet(ts_word_count);
	endtask

	initial begin
		void'($urandom(32'h3154));
		S_AXI_ARESETN = 1'b0;
		mpeg_data = 8'h00;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		pid = watched_pid;
		pump_data_enable = 1'b0;
		continuity = 4'd0;
		repeat (reset_cycles) @(posedge mpeg_clk);
		S_AXI_ARESETN <= 1'b1;
		@(negedge mpeg_clk);
		compare_bit("out_valid", 1'b0, out_valid);
		compare_bit("ready_for_read", 1'b0, ready_for_read);
		compare_bit("matched_state", 1'b0, matched_state);
		compare_bit("packet_ready", 1'b0, packet_ready);
		test_matching_capture();
		test_pid_mismatch();
		test_bad_sync();
		test_valid_gaps();
		test_second_dropped();
		test_pause_resume();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/ts_monitor_pkg.sv
hdl/ts_header_parser.sv
hdl/ts_packet_buffer.sv
hdl/ts_packet_pump.sv
hdl/ts_monitor.sv
tb/tb_clock_gen.sv
tb/ts_monitor_chk.sv
tb/ts_monitor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the ts_monitor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f vlog.f --top-module ts_monitor_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vts_monitor_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
